//--- source/soc_map_pkg.sv
package soc_map_pkg;

	//----------------------------------------------------------------------
	// Bus geometry
	//----------------------------------------------------------------------
	localparam int ADDR_W      = 32;
	localparam int NUM_REGIONS = 6;

	// Region field sits just below the shadow bit
	localparam int REGION_W    = 3;

	// High bits that must all be zero for a null access (lowest 256 KiB)
	localparam int GUARD_W     = 14;

	// Bit position of each slave in the one-hot select
	localparam int REGION_FLASH = 0;
	localparam int REGION_DEBUG = 1;
	localparam int REGION_USB   = 2;
	localparam int REGION_ETH   = 3;
	localparam int REGION_SDRAM = 4;
	localparam int REGION_CSR   = 5;

	//----------------------------------------------------------------------
	// Bus address, seen by the decoder and by the null guard
	//----------------------------------------------------------------------
	typedef union packed {
		// Region view, bit 31 selects the shadow copy
		struct packed {
			logic                       shadow;
			logic [REGION_W-1:0]        region;
			logic [ADDR_W-REGION_W-2:0] offset;
		} rgn;
		// Guard view
		struct packed {
			logic [GUARD_W-1:0]        guard;
			logic [ADDR_W-GUARD_W-1:0] offset;
		} grd;
	} bus_addr_u;

endpackage

//--- source/soc_reset_pkg.sv
package soc_reset_pkg;

	//----------------------------------------------------------------------
	// Reset timer
	//----------------------------------------------------------------------
	localparam int RST_COUNT_W = 20;

	typedef logic [RST_COUNT_W-1:0] rst_count_t;

	// Flash leaves reset early, the CPU waits for the full count
	localparam rst_count_t DEFAULT_FLASH_RST_CYCLES = rst_count_t'(128);
	localparam rst_count_t DEFAULT_SYS_RST_CYCLES   = rst_count_t'(1048575);

	//----------------------------------------------------------------------
	// Sequencer states
	//----------------------------------------------------------------------
	typedef enum logic [1:0] {
		FLASH_HOLD,
		CPU_HOLD,
		RUN
	} rst_state_t;

endpackage

//--- source/reset_sequencer.sv
`timescale 1ns/1ps

module reset_sequencer (
	input  logic       sys_clk,
	input  logic       trigger_reset,
	input  logic [2:0] btn_i,
	input  logic       hard_reset_i,
	input  logic       flash_done_i,
	input  logic       sys_done_i,
	output logic       timer_clear_o,
	output logic       flash_rst_n_o,
	output logic       sys_rst_o
);

	soc_reset_pkg::rst_state_t state_q;
	soc_reset_pkg::rst_state_t state_d;
	logic                      restart_q;

	//----------------------------------------------------------------------
	// Restart request
	//----------------------------------------------------------------------
	// All three buttons together, or a software hard reset
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			restart_q <= 1'b0;
		end else begin
			restart_q <= (&btn_i) | hard_reset_i;
		end
	end

	// Timer restarts one edge after the request is sampled
	assign timer_clear_o = restart_q;

	//----------------------------------------------------------------------
	// Release order
	//----------------------------------------------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			soc_reset_pkg::FLASH_HOLD: begin
				if (flash_done_i) begin
					state_d = soc_reset_pkg::CPU_HOLD;
				end
			end
			soc_reset_pkg::CPU_HOLD: begin
				if (sys_done_i) begin
					state_d = soc_reset_pkg::RUN;
				end
			end
			soc_reset_pkg::RUN: begin
				state_d = soc_reset_pkg::RUN;
			end
			default: begin
				state_d = soc_reset_pkg::FLASH_HOLD;
			end
		endcase
	end

	// A held request keeps the whole sequence at its start
	always_ff @(posedge sys_clk) begin
		if (trigger_reset || restart_q) begin
			state_q <= soc_reset_pkg::FLASH_HOLD;
		end else begin
			state_q <= state_d;
		end
	end

	// Flash must be out of reset before the CPU starts fetching from it
	assign flash_rst_n_o = (state_q != soc_reset_pkg::FLASH_HOLD);
	assign sys_rst_o     = (state_q != soc_reset_pkg::RUN);

endmodule

//--- source/reset_timer.sv
`timescale 1ns/1ps

module reset_timer #(
	parameter soc_reset_pkg::rst_count_t FLASH_RST_CYCLES =
		soc_reset_pkg::DEFAULT_FLASH_RST_CYCLES,
	parameter soc_reset_pkg::rst_count_t SYS_RST_CYCLES =
		soc_reset_pkg::DEFAULT_SYS_RST_CYCLES
) (
	input  logic sys_clk,
	input  logic trigger_reset,
	input  logic clear_i,
	output logic flash_done_o,
	output logic sys_done_o
);

	// Flags look one count ahead so the sequencer moves on the threshold edge
	localparam soc_reset_pkg::rst_count_t FLASH_LAST = FLASH_RST_CYCLES - 1'b1;
	localparam soc_reset_pkg::rst_count_t SYS_LAST   = SYS_RST_CYCLES - 1'b1;
	localparam soc_reset_pkg::rst_count_t COUNT_MAX  = '1;

	soc_reset_pkg::rst_count_t count_q;

	// Saturates at all ones
	always_ff @(posedge sys_clk) begin
		if (trigger_reset || clear_i) begin
			count_q <= '0;
		end else if (count_q != COUNT_MAX) begin
			count_q <= count_q + 1'b1;
		end
	end

	assign flash_done_o = (count_q >= FLASH_LAST);
	assign sys_done_o   = (count_q >= SYS_LAST);

endmodule

//--- source/wb_region_decoder.sv
`timescale 1ns/1ps

module wb_region_decoder (
	input  soc_map_pkg::bus_addr_u                mst_adr_i,
	input  logic                                  mst_cyc_i,
	input  logic                                  mst_stb_i,
	input  logic [soc_map_pkg::NUM_REGIONS-1:0]   slv_ack_i,
	output logic [soc_map_pkg::NUM_REGIONS-1:0]   slv_stb_o,
	output logic                                  mst_ack_o
);

	logic [soc_map_pkg::NUM_REGIONS-1:0] region_sel;
	logic                                access;

	//----------------------------------------------------------------------
	// Region select
	//----------------------------------------------------------------------
	// Shadow bit is not looked at, so 0x8xxx_xxxx aliases 0x0xxx_xxxx
	always_comb begin
		region_sel = '0;
		casez (mst_adr_i.rgn.region)
			3'b000:  region_sel[soc_map_pkg::REGION_FLASH] = 1'b1;
			3'b001:  region_sel[soc_map_pkg::REGION_DEBUG] = 1'b1;
			3'b010:  region_sel[soc_map_pkg::REGION_USB]   = 1'b1;
			3'b011:  region_sel[soc_map_pkg::REGION_ETH]   = 1'b1;
			// SDRAM and CSR each span two region values
			3'b10?:  region_sel[soc_map_pkg::REGION_SDRAM] = 1'b1;
			3'b11?:  region_sel[soc_map_pkg::REGION_CSR]   = 1'b1;
			default: region_sel = '0;
		endcase
	end

	assign access = mst_cyc_i & mst_stb_i;

	// Strobe follows the master for as long as it holds the cycle
	assign slv_stb_o = region_sel & {soc_map_pkg::NUM_REGIONS{access}};

	//----------------------------------------------------------------------
	// Acknowledge return
	//----------------------------------------------------------------------
	// Acks from unselected slaves never reach the master
	assign mst_ack_o = |(slv_stb_o & slv_ack_i);

endmodule

//--- source/bus_error_guard.sv
`timescale 1ns/1ps

module bus_error_guard (
	input  logic                   sys_clk,
	input  logic                   trigger_reset,
	input  soc_map_pkg::bus_addr_u mst_adr_i,
	input  logic                   bus_errors_en_i,
	input  logic                   mst_ack_i,
	output logic                   mst_err_o
);

	logic null_hit_q;

	// Catches null pointer accesses, address is stable for the whole cycle
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			null_hit_q <= 1'b0;
		end else begin
			null_hit_q <= (mst_adr_i.grd.guard == '0);
		end
	end

	// Error comes together with the ack, not instead of it
	assign mst_err_o = bus_errors_en_i & null_hit_q & mst_ack_i;

endmodule

//--- source/soc_glue.sv
`timescale 1ns/1ps

module soc_glue #(
	parameter soc_reset_pkg::rst_count_t FLASH_RST_CYCLES =
		soc_reset_pkg::DEFAULT_FLASH_RST_CYCLES,
	parameter soc_reset_pkg::rst_count_t SYS_RST_CYCLES =
		soc_reset_pkg::DEFAULT_SYS_RST_CYCLES
) (
	input  logic                                sys_clk,
	input  logic                                trigger_reset,
	input  logic [2:0]                          btn_i,
	input  logic                                hard_reset_i,
	input  logic                                bus_errors_en_i,
	input  logic [soc_map_pkg::ADDR_W-1:0]      mst_adr_i,
	input  logic                                mst_cyc_i,
	input  logic                                mst_stb_i,
	input  logic [soc_map_pkg::NUM_REGIONS-1:0] slv_ack_i,
	output logic                                flash_rst_n_o,
	output logic                                sys_rst_o,
	output logic [soc_map_pkg::NUM_REGIONS-1:0] slv_stb_o,
	output logic                                mst_ack_o,
	output logic                                mst_err_o
);

	logic timer_clear;
	logic flash_done;
	logic sys_done;

	//----------------------------------------------------------------------
	// Reset sequencing
	//----------------------------------------------------------------------
	reset_sequencer u_reset_sequencer (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.btn_i         (btn_i),
		.hard_reset_i  (hard_reset_i),
		.flash_done_i  (flash_done),
		.sys_done_i    (sys_done),
		.timer_clear_o (timer_clear),
		.flash_rst_n_o (flash_rst_n_o),
		.sys_rst_o     (sys_rst_o)
	);

	reset_timer #(
		.FLASH_RST_CYCLES (FLASH_RST_CYCLES),
		.SYS_RST_CYCLES   (SYS_RST_CYCLES)
	) u_reset_timer (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.clear_i       (timer_clear),
		.flash_done_o  (flash_done),
		.sys_done_o    (sys_done)
	);

	//----------------------------------------------------------------------
	// Bus path
	//----------------------------------------------------------------------
	wb_region_decoder u_wb_region_decoder (
		.mst_adr_i (mst_adr_i),
		.mst_cyc_i (mst_cyc_i),
		.mst_stb_i (mst_stb_i),
		.slv_ack_i (slv_ack_i),
		.slv_stb_o (slv_stb_o),
		.mst_ack_o (mst_ack_o)
	);

	bus_error_guard u_bus_error_guard (
		.sys_clk         (sys_clk),
		.trigger_reset   (trigger_reset),
		.mst_adr_i       (mst_adr_i),
		.bus_errors_en_i (bus_errors_en_i),
		.mst_ack_i       (mst_ack_o),
		.mst_err_o       (mst_err_o)
	);

endmodule

//--- dv/soc_glue_tb.sv
`timescale 1ns/1ps

module soc_glue_tb;

	localparam int HALF_PERIOD  = 4;
	localparam int RESET_CYCLES = 8;
	localparam int FLASH_CYCLES = 16;
	localparam int SYS_CYCLES   = 200;
	localparam int NUM_VEC      = 21;
	localparam int NUM_RANDOM   = 200;
	// Three reset sequences near 210 cycles, vectors at 3 cycles each, then margin
	localparam int TIMEOUT_CYCLES = 2000;
	localparam logic [31:0] SEED  = 32'he2da_33f9;

	logic                                sys_clk;
	logic                                trigger_reset;
	logic [2:0]                          btn;
	logic                                hard_reset;
	logic                                bus_errors_en;
	logic [soc_map_pkg::ADDR_W-1:0]      mst_adr;
	logic                                mst_cyc;
	logic                                mst_stb;
	logic [soc_map_pkg::NUM_REGIONS-1:0] slv_ack;
	logic                                flash_rst_n;
	logic                                sys_rst;
	logic [soc_map_pkg::NUM_REGIONS-1:0] slv_stb;
	logic                                mst_ack;
	logic                                mst_err;

	logic [63:0] golden_mem [0:NUM_VEC-1];
	int          error_count;
	int          check_count;
	int          cycle_count;

	soc_glue #(
		.FLASH_RST_CYCLES (soc_reset_pkg::rst_count_t'(FLASH_CYCLES)),
		.SYS_RST_CYCLES   (soc_reset_pkg::rst_count_t'(SYS_CYCLES))
	) dut_i (
		.sys_clk         (sys_clk),
		.trigger_reset   (trigger_reset),
		.btn_i           (btn),
		.hard_reset_i    (hard_reset),
		.bus_errors_en_i (bus_errors_en),
		.mst_adr_i       (mst_adr),
		.mst_cyc_i       (mst_cyc),
		.mst_stb_i       (mst_stb),
		.slv_ack_i       (slv_ack),
		.flash_rst_n_o   (flash_rst_n),
		.sys_rst_o       (sys_rst),
		.slv_stb_o       (slv_stb),
		.mst_ack_o       (mst_ack),
		.mst_err_o       (mst_err)
	);

	always #HALF_PERIOD sys_clk = ~sys_clk;

	//----------------------------------------------------------------------
	// Reference rules
	//----------------------------------------------------------------------
	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Bit 31 only picks the shadow copy
	function automatic logic [5:0] region_strobe(input logic [31:0] addr);
		logic [5:0] sel;
		sel = '0;
		if (addr[30] && addr[29]) begin
			sel[soc_map_pkg::REGION_CSR] = 1'b1;
		end else if (addr[30]) begin
			sel[soc_map_pkg::REGION_SDRAM] = 1'b1;
		end else begin
			case (addr[29:28])
				2'd0: sel[soc_map_pkg::REGION_FLASH] = 1'b1;
				2'd1: sel[soc_map_pkg::REGION_DEBUG] = 1'b1;
				2'd2: sel[soc_map_pkg::REGION_USB]   = 1'b1;
				default: sel[soc_map_pkg::REGION_ETH] = 1'b1;
			endcase
		end
		return sel;
	endfunction

	function automatic logic is_null_access(input logic [31:0] addr);
		return addr[soc_map_pkg::ADDR_W-1 -: soc_map_pkg::GUARD_W] == '0;
	endfunction

	task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("FAIL %0t: %s got 0x%0h expected 0x%0h", $time, what, actual, expected);
		end
	endtask

	//----------------------------------------------------------------------
	// Stimulus tasks, entered and left on a falling edge
	//----------------------------------------------------------------------
	// Edge 0 is the last edge that held the sequence at its start
	task automatic verify_reset_sequence(input string label);
		int edge_n;
		for (edge_n = 1; edge_n <= SYS_CYCLES + 4; edge_n++) begin
			@(negedge sys_clk);
			compare_value(flash_rst_n, edge_n >= FLASH_CYCLES,
				$sformatf("%s flash reset at edge %0d", label, edge_n));
			compare_value(sys_rst, edge_n < SYS_CYCLES,
				$sformatf("%s system reset at edge %0d", label, edge_n));
		end
	endtask

	task automatic restart_sequence(input logic [2:0] buttons, input logic hard,
			input string label);
		btn = buttons;
		hard_reset = hard;
		@(negedge sys_clk);
		btn = 3'b000;
		hard_reset = 1'b0;
		// Request is only registered so far
		compare_value({flash_rst_n, sys_rst}, 2'b10, {label, " outputs on request edge"});
		@(negedge sys_clk);
		compare_value({flash_rst_n, sys_rst}, 2'b01, {label, " outputs after restart"});
		verify_reset_sequence(label);
	endtask

	task automatic run_bus_access(input logic [31:0] addr, input logic [5:0] ack_mask,
			input logic en, input logic [5:0] exp_stb, input logic exp_err,
			input string label);
		logic exp_ack;
		exp_ack = |(exp_stb & ack_mask);
		mst_adr = addr;
		bus_errors_en = en;
		slv_ack = ack_mask;
		mst_cyc = 1'b0;
		mst_stb = 1'b1;
		#1;
		compare_value(slv_stb, 0, {label, " strobes with cyc low"});
		compare_value({mst_ack, mst_err}, 0, {label, " ack and error with cyc low"});
		@(negedge sys_clk);
		mst_cyc = 1'b1;
		slv_ack = '0;
		#1;
		compare_value(slv_stb, exp_stb, {label, " strobes"});
		compare_value(mst_ack, 0, {label, " ack before slave"});
		@(negedge sys_clk);
		slv_ack = ack_mask;
		#1;
		compare_value(slv_stb, exp_stb, {label, " strobes during ack"});
		compare_value(mst_ack, exp_ack, {label, " master ack"});
		compare_value(mst_err, exp_err, {label, " bus error"});
		@(negedge sys_clk);
		mst_cyc = 1'b0;
		mst_stb = 1'b0;
		slv_ack = '0;
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge sys_clk);
			cycle_count++;
		end
		$display("Run timed out after %0d cycles without finishing", cycle_count);
		$display("CHECKS FAILED");
		$finish;
	end

	//----------------------------------------------------------------------
	// Main sequence
	//----------------------------------------------------------------------
	initial begin
		int          i;
		logic [63:0] vec;
		logic [31:0] rand_state;
		logic [31:0] addr;
		logic [5:0]  ack_mask;
		logic        en;
		error_count = 0;
		check_count = 0;
		sys_clk = 1'b0;
		trigger_reset = 1'b1;
		btn = 3'b000;
		hard_reset = 1'b0;
		bus_errors_en = 1'b0;
		mst_adr = '0;
		mst_cyc = 1'b0;
		mst_stb = 1'b0;
		slv_ack = '0;
		rand_state = SEED;
		$readmemh("dv/soc_glue_golden.mem", golden_mem);
		repeat (RESET_CYCLES) @(negedge sys_clk);
		compare_value({flash_rst_n, sys_rst}, 2'b01, "outputs during trigger_reset");
		compare_value({slv_stb, mst_ack, mst_err}, 0, "bus outputs idle after reset");
		trigger_reset = 1'b0;
		verify_reset_sequence("power-on");

		// Any two buttons are ignored
		for (i = 0; i < 3; i++) begin
			btn = ~(3'b001 << i);
			repeat (2) begin
				@(negedge sys_clk);
				compare_value({flash_rst_n, sys_rst}, 2'b10, "outputs with two buttons");
			end
		end
		btn = 3'b000;
		restart_sequence(3'b111, 1'b0, "button restart");
		restart_sequence(3'b000, 1'b1, "hard reset");

		if ($isunknown(golden_mem[NUM_VEC-1])) begin
			$display("Golden vector file dv/soc_glue_golden.mem could not be read in full");
			error_count++;
		end else begin
			for (i = 0; i < NUM_VEC; i++) begin
				vec = golden_mem[i];
				run_bus_access(vec[63:32], vec[13:8], vec[7], vec[6:1], vec[0],
					$sformatf("vector %0d", i));
			end
		end

		for (i = 0; i < NUM_RANDOM; i++) begin
			rand_state = next_random(rand_state);
			addr = rand_state;
			// Every fourth address lands in the null region
			if (i % 4 == 0) begin
				addr = addr & 32'h0003_ffff;
			end
			rand_state = next_random(rand_state);
			ack_mask = rand_state[5:0];
			en = rand_state[8];
			run_bus_access(addr, ack_mask, en, region_strobe(addr),
				en & is_null_access(addr) & (|(region_strobe(addr) & ack_mask)),
				$sformatf("random %0d addr 0x%08h", i, addr));
		end

		$display("Closing: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- soc_glue.f
source/soc_map_pkg.sv
source/soc_reset_pkg.sv
source/reset_sequencer.sv
source/reset_timer.sv
source/wb_region_decoder.sv
source/bus_error_guard.sv
source/soc_glue.sv
dv/soc_glue_tb.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= soc_glue_tb
RTL_TOP    ?= soc_glue
FILELIST   ?= soc_glue.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/soc_glue_golden.mem
// Columns: address [63:32], slave ack mask [13:8], bus error enable [7],
// expected one-hot strobes [6:1], expected bus error [0]
0000100000000183
8000100000000182
0001000000000183
0001000000000102
0001000000003e82
0004000000000182
8000000000000182
1000000000000284
9000000000000284
2000004000000488
a000004000003b88
3000000000000890
b123456800003f90
40000000000010a0
5ffffffc00001020
d0000004000030a0
60000000000020c0
70001234000020c0
e000000000001fc0
0003fffc00000183
0000000000000082
